/* list.f */
hdl/morse_pkg.sv
hdl/morse_lut.sv
hdl/morse_entry.sv
hdl/char_fifo.sv
hdl/morse_wb_regs.sv
hdl/morse_keypad_top.sv
dv/morse_tb.sv

/* run.sh */
#!/bin/sh
rm -f sim.log && \
verilator --binary --timing --assert -f list.f --top-module morse_tb \
    -Mdir obj_dir -o morse_sim && \
./obj_dir/morse_sim | tee sim.log && \
grep -q '^\*\* PASS \*\*$' sim.log && \
echo "simulation passed" || \
{ echo "simulation failed"; exit 1; }

/* dv/morse_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module morse_tb;
    import morse_pkg::*;

    localparam int clk_period = 8;
    // rough count of keypad events over all tests
    localparam int planned_keys = 250;

    logic              clk;
    logic              rst;
    logic [3:0]        key;
    logic              key_strobe;
    logic              backspace;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [wb_aw-1:0]  wb_adr;
    logic [wb_dw-1:0]  wb_dat_w;
    logic [wb_dw-1:0]  wb_dat_r;
    logic              wb_ack;

    logic [31:0]       lcg_state;
    logic [code_w-1:0] exp_q[$];
    logic [code_w-1:0] sb_code;
    int                order[36];

    // indexed by character code with the digits before a to z
    string morse_tab [36] = '{
        "-----", ".----", "..---", "...--", "....-", ".....",
        "-....", "--...", "---..", "----.",
        ".-", "-...", "-.-.", "-..", ".", "..-.", "--.", "....", "..",
        ".---", "-.-", ".-..", "--", "-.", "---", ".--.", "--.-", ".-.",
        "...", "-", "..-", "...-", ".--", "-..-", "-.--", "--.."
    };

    morse_keypad_top i_morse_keypad_top (
        .clk        (clk),
        .rst        (rst),
        .key        (key),
        .key_strobe (key_strobe),
        .backspace  (backspace),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // packs {count, pattern} with the newest symbol in bit 0 and at most five kept
    function automatic logic [7:0] pack_seq(input string s);
        logic [4:0] p;
        logic [2:0] n;
        p = '0;
        n = '0;
        for (int i = 0; i < s.len() && i < 5; i++) begin
            p = {p[3:0], s.getc(i) == "-"};
            n = n + 3'd1;
        end
        return {n, p};
    endfunction

    function automatic logic [7:0] encode(input int c);
        return pack_seq(morse_tab[c]);
    endfunction

    function automatic logic [code_w-1:0] expect_code(input logic [4:0] p, input logic [2:0] n);
        for (int c = 0; c < 36; c++) begin
            if (encode(c) == {n, p}) begin
                return code_w'(c);
            end
        end
        return code_invalid;
    endfunction

    // all drive tasks start and end just after a falling edge
    task automatic send_symbol(input logic [3:0] k);
        key = k;
        key_strobe = 1'b1;
        repeat (4) @(negedge clk);
        key_strobe = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic send_backspace();
        backspace = 1'b1;
        repeat (4) @(negedge clk);
        backspace = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic send_string(input string s);
        for (int i = 0; i < s.len(); i++) begin
            send_symbol(s.getc(i) == "-" ? key_dash : key_dot);
        end
    endtask

    task automatic wait_ack();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_ack && n < 20);
        if (!wb_ack) begin
            abort_run("wishbone slave never acknowledged the access");
        end
        check("ack wait cycles", n, 2);
    endtask

    task automatic wb_write(input logic [wb_aw-1:0] adr, input logic [wb_dw-1:0] data);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge clk);
    endtask

    task automatic wb_read(input logic [wb_aw-1:0] adr, output logic [wb_dw-1:0] data);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge clk);
    endtask

    task automatic enter_char(input int c, input bit stored);
        logic [7:0] seq;
        seq = encode(c);
        send_string(morse_tab[c]);
        if (stored) begin
            exp_q.push_back(expect_code(seq[4:0], seq[7:5]));
        end
        send_symbol(key_enter);
    endtask

    task automatic check_entry(input logic [7:0] exp_seq);
        logic [31:0] st;
        wb_read(reg_status, st);
        check("status count", 32'(st[st_cnt_lsb +: cnt_w]), 32'(exp_seq[7:5]));
        check("status pattern", 32'(st[st_pat_lsb +: sym_w]), 32'(exp_seq[4:0]));
    endtask

    task automatic check_flags(input int lvl, input bit full_e, input bit ovf_e, input bit rej_e);
        logic [31:0] st;
        wb_read(reg_status, st);
        check("status level", 32'(st[st_level_lsb +: lvl_w]), lvl);
        check("status empty", 32'(st[st_empty_bit]), 32'(lvl == 0));
        check("status full", 32'(st[st_full_bit]), 32'(full_e));
        check("status overflow", 32'(st[st_ovf_bit]), 32'(ovf_e));
        check("status reject", 32'(st[st_rej_bit]), 32'(rej_e));
    endtask

    task automatic drain(input int n);
        logic [31:0] d;
        for (int i = 0; i < n; i++) begin
            wb_read(reg_data, d);
            check("data valid", 32'(d[dat_valid_bit]), 32'd1);
        end
    endtask

    // compares every valid character read with the oldest expectation
    always @(negedge clk) begin
        if (!rst && wb_ack && !wb_we && wb_adr == reg_data && wb_dat_r[dat_valid_bit]) begin
            if (exp_q.size() == 0) begin
                abort_run("a character was read back while none was expected");
            end else begin
                sb_code = exp_q.pop_front();
                check("wb_dat_r code", 32'(wb_dat_r[dat_code_lsb +: code_w]), 32'(sb_code));
            end
        end
    end

    initial begin
        #(planned_keys * 2000 * clk_period);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        logic [31:0] d;
        logic [7:0]  seq;
        int          j;
        int          tmp;
        int          lvl;
        clk        = 1'b0;
        rst        = 1'b1;
        key        = '0;
        key_strobe = 1'b0;
        backspace  = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        lcg_state  = 32'h9929_ec80;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        wb_write(reg_ctrl, 32'h1);

        // every character once in lcg order
        for (int i = 0; i < 36; i++) begin
            order[i] = i;
        end
        for (int i = 35; i > 0; i--) begin
            j        = int'(lcg_next() >> 8) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int b = 0; b < 36; b += 8) begin
            lvl = (36 - b < 8) ? 36 - b : 8;
            for (int i = 0; i < lvl; i++) begin
                enter_char(order[b + i], 1'b1);
            end
            check_flags(lvl, lvl == 8, 1'b0, 1'b0);
            drain(lvl);
        end

        // backspace drops the newest symbol
        send_string("-.-.");
        send_backspace();
        seq = pack_seq("-.-");
        check_entry(seq);
        exp_q.push_back(expect_code(seq[4:0], seq[7:5]));
        send_symbol(key_enter);
        drain(1);

        // a sixth symbol is ignored
        send_string("--...-");
        seq = pack_seq("--...-");
        check_entry(seq);
        exp_q.push_back(expect_code(seq[4:0], seq[7:5]));
        send_symbol(key_enter);
        drain(1);

        // unknown pattern followed by an empty commit
        send_string("----");
        seq = pack_seq("----");
        send_symbol(key_enter);
        check_flags(0, 1'b0, 1'b0, expect_code(seq[4:0], seq[7:5]) == code_invalid);
        wb_write(reg_ctrl, 32'h3);
        check_flags(0, 1'b0, 1'b0, 1'b0);
        send_symbol(key_enter);
        check_flags(0, 1'b0, 1'b0, 1'b1);
        wb_write(reg_ctrl, 32'h3);
        check_flags(0, 1'b0, 1'b0, 1'b0);

        // nine commits into eight entries
        for (int i = 0; i < 9; i++) begin
            enter_char(int'(lcg_next() >> 8) % 36, i < 8);
        end
        check_flags(8, 1'b1, 1'b1, 1'b0);
        drain(8);
        wb_read(reg_data, d);
        check("data word when empty", d, 32'h0);
        wb_write(reg_ctrl, 32'h3);
        check_flags(0, 1'b0, 1'b0, 1'b0);

        // entry disabled
        wb_write(reg_ctrl, 32'h0);
        send_string("-..");
        check_entry(8'h00);
        send_symbol(key_enter);
        check_flags(0, 1'b0, 1'b0, 1'b0);
        wb_read(reg_data, d);
        check("data word while disabled", d, 32'h0);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/morse_keypad_top.sv */
`timescale 1ns/1ps
`default_nettype none

module morse_keypad_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [3:0]                  key,
    input  logic                        key_strobe,
    input  logic                        backspace,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [morse_pkg::wb_aw-1:0] wb_adr,
    input  logic [morse_pkg::wb_dw-1:0] wb_dat_w,
    output logic [morse_pkg::wb_dw-1:0] wb_dat_r,
    output logic                        wb_ack
);
    import morse_pkg::*;

    logic              entry_en;
    logic [sym_w-1:0]  cur_pattern;
    logic [cnt_w-1:0]  cur_count;
    logic              push;
    logic [code_w-1:0] push_code;
    logic              reject;
    logic [code_w-1:0] head_code;
    logic [lvl_w-1:0]  level;
    logic              empty;
    logic              full;
    logic              dropped;
    logic              pop;

    morse_entry i_morse_entry (
        .clk         (clk),
        .rst         (rst),
        .entry_en    (entry_en),
        .key         (key),
        .key_strobe  (key_strobe),
        .backspace   (backspace),
        .cur_pattern (cur_pattern),
        .cur_count   (cur_count),
        .push        (push),
        .push_code   (push_code),
        .reject      (reject)
    );

    char_fifo i_char_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_code (push_code),
        .pop       (pop),
        .head_code (head_code),
        .level     (level),
        .empty     (empty),
        .full      (full),
        .dropped   (dropped)
    );

    morse_wb_regs i_morse_wb_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .entry_en    (entry_en),
        .reject      (reject),
        .dropped     (dropped),
        .cur_pattern (cur_pattern),
        .cur_count   (cur_count),
        .head_code   (head_code),
        .level       (level),
        .empty       (empty),
        .full        (full),
        .pop         (pop)
    );

endmodule

`default_nettype wire

/* hdl/morse_wb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module morse_wb_regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [morse_pkg::wb_aw-1:0]  wb_adr,
    input  logic [morse_pkg::wb_dw-1:0]  wb_dat_w,
    output logic [morse_pkg::wb_dw-1:0]  wb_dat_r,
    output logic                         wb_ack,
    output logic                         entry_en,
    input  logic                         reject,
    input  logic                         dropped,
    input  logic [morse_pkg::sym_w-1:0]  cur_pattern,
    input  logic [morse_pkg::cnt_w-1:0]  cur_count,
    input  logic [morse_pkg::code_w-1:0] head_code,
    input  logic [morse_pkg::lvl_w-1:0]  level,
    input  logic                         empty,
    input  logic                         full,
    output logic                         pop
);
    import morse_pkg::*;

    logic             req_q;
    logic             ovf_flag;
    logic             rej_flag;
    logic             wr_ctrl;
    logic [wb_dw-1:0] rd_word;

    // first edge latches the request, second edge answers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_q  <= 1'b0;
            wb_ack <= 1'b0;
            pop    <= 1'b0;
        end else begin
            req_q  <= wb_cyc & wb_stb & ~req_q & ~wb_ack;
            wb_ack <= req_q;
            // pop lands on the ack cycle of a data read
            pop    <= req_q & ~wb_we & (wb_adr == reg_data) & ~empty;
        end
    end

    assign wr_ctrl = req_q & wb_we & (wb_adr == reg_ctrl);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entry_en <= 1'b0;
            ovf_flag <= 1'b0;
            rej_flag <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                entry_en <= wb_dat_w[ctrl_en_bit];
            end
            // a new event in the clearing cycle still sticks
            if (dropped) begin
                ovf_flag <= 1'b1;
            end else if (wr_ctrl && wb_dat_w[ctrl_clr_bit]) begin
                ovf_flag <= 1'b0;
            end
            if (reject) begin
                rej_flag <= 1'b1;
            end else if (wr_ctrl && wb_dat_w[ctrl_clr_bit]) begin
                rej_flag <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (wb_adr)
            reg_data: begin
                rd_word[dat_code_lsb +: code_w] = empty ? '0 : head_code;
                rd_word[dat_valid_bit]          = ~empty;
            end
            reg_status: begin
                rd_word[st_level_lsb +: lvl_w] = level;
                rd_word[st_empty_bit]          = empty;
                rd_word[st_full_bit]           = full;
                rd_word[st_ovf_bit]            = ovf_flag;
                rd_word[st_rej_bit]            = rej_flag;
                rd_word[st_cnt_lsb +: cnt_w]   = cur_count;
                rd_word[st_pat_lsb +: sym_w]   = cur_pattern;
            end
            reg_ctrl: rd_word[ctrl_en_bit] = entry_en;
            default:  rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (req_q) begin
            wb_dat_r <= rd_word;
        end
    end

    a_ack_follows_stb: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_stb));

endmodule

`default_nettype wire

/* hdl/char_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module char_fifo (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         push,
    input  logic [morse_pkg::code_w-1:0] push_code,
    input  logic                         pop,
    output logic [morse_pkg::code_w-1:0] head_code,
    output logic [morse_pkg::lvl_w-1:0]  level,
    output logic                         empty,
    output logic                         full,
    output logic                         dropped
);
    import morse_pkg::*;

    logic [code_w-1:0]             mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic                          do_push;
    logic                          do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_code;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            level   <= '0;
            dropped <= 1'b0;
        end else begin
            dropped <= push & full;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign head_code = mem[rd_ptr];
    assign empty     = (level == '0);
    assign full      = (level == lvl_w'(fifo_depth));

    a_level_bound: assert property (@(posedge clk) disable iff (rst)
        level <= lvl_w'(fifo_depth));

endmodule

`default_nettype wire

/* hdl/morse_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module morse_entry (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         entry_en,
    input  logic [3:0]                   key,
    input  logic                         key_strobe,
    input  logic                         backspace,
    output logic [morse_pkg::sym_w-1:0]  cur_pattern,
    output logic [morse_pkg::cnt_w-1:0]  cur_count,
    output logic                         push,
    output logic [morse_pkg::code_w-1:0] push_code,
    output logic                         reject
);
    import morse_pkg::*;

    // two sync stages plus one edge reference flop
    logic [2:0]        stb_sync;
    logic [2:0]        bs_sync;
    logic              stb_evt;
    logic              bs_evt;
    logic [3:0]        key_q;
    logic [code_w-1:0] lut_code;
    logic              lut_found;
    logic              at_max;
    logic              commit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            stb_sync <= '0;
            bs_sync  <= '0;
            stb_evt  <= 1'b0;
            bs_evt   <= 1'b0;
        end else begin
            stb_sync <= {stb_sync[1:0], key_strobe};
            bs_sync  <= {bs_sync[1:0], backspace};
            stb_evt  <= stb_sync[1] & ~stb_sync[2];
            bs_evt   <= bs_sync[1] & ~bs_sync[2];
        end
    end

    // key is stable while the strobe is up, grab it with the edge
    always_ff @(posedge clk) begin
        if (stb_sync[1] && !stb_sync[2]) begin
            key_q <= key;
        end
    end

    morse_lut i_morse_lut (
        .pattern (cur_pattern),
        .count   (cur_count),
        .code    (lut_code),
        .found   (lut_found)
    );

    assign at_max = (cur_count == cnt_w'(max_syms));
    // backspace wins, so a same-cycle enter is lost
    assign commit = entry_en & stb_evt & ~bs_evt & (key_q == key_enter);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_pattern <= '0;
            cur_count   <= '0;
            push        <= 1'b0;
            reject      <= 1'b0;
        end else begin
            push   <= 1'b0;
            reject <= 1'b0;
            if (!entry_en) begin
                cur_pattern <= '0;
                cur_count   <= '0;
            end else if (bs_evt) begin
                cur_pattern <= {1'b0, cur_pattern[sym_w-1:1]};
                if (cur_count != '0) begin
                    cur_count <= cur_count - 1'b1;
                end
            end else if (commit) begin
                push        <= lut_found;
                reject      <= ~lut_found;
                cur_pattern <= '0;
                cur_count   <= '0;
            end else if (stb_evt && !at_max &&
                         (key_q == key_dot || key_q == key_dash)) begin
                // new symbol enters on the right
                cur_pattern <= {cur_pattern[sym_w-2:0], key_q == key_dash};
                cur_count   <= cur_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            push_code <= lut_code;
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (rst)
        cur_count <= cnt_w'(max_syms));

    a_push_xor_reject: assert property (@(posedge clk) disable iff (rst)
        !(push && reject));

endmodule

`default_nettype wire

/* hdl/morse_lut.sv */
`timescale 1ns/1ps
`default_nettype none

module morse_lut (
    input  logic [morse_pkg::sym_w-1:0]  pattern,
    input  logic [morse_pkg::cnt_w-1:0]  count,
    output logic [morse_pkg::code_w-1:0] code,
    output logic                         found
);
    import morse_pkg::*;

    // key is {count, pattern}; first symbol sits in the highest used bit
    always_comb begin
        found = 1'b1;
        case ({count, pattern})
            // letters
            8'b010_00001: code = 6'h0a;
            8'b100_01000: code = 6'h0b;
            8'b100_01010: code = 6'h0c;
            8'b011_00100: code = 6'h0d;
            8'b001_00000: code = 6'h0e;
            8'b100_00010: code = 6'h0f;
            8'b011_00110: code = 6'h10;
            8'b100_00000: code = 6'h11;
            8'b010_00000: code = 6'h12;
            8'b100_00111: code = 6'h13;
            8'b011_00101: code = 6'h14;
            8'b100_00100: code = 6'h15;
            8'b010_00011: code = 6'h16;
            8'b010_00010: code = 6'h17;
            8'b011_00111: code = 6'h18;
            8'b100_00110: code = 6'h19;
            8'b100_01101: code = 6'h1a;
            8'b011_00010: code = 6'h1b;
            8'b011_00000: code = 6'h1c;
            8'b001_00001: code = 6'h1d;
            8'b011_00001: code = 6'h1e;
            8'b100_00001: code = 6'h1f;
            8'b011_00011: code = 6'h20;
            8'b100_01001: code = 6'h21;
            8'b100_01011: code = 6'h22;
            8'b100_01100: code = 6'h23;
            // digits, always five symbols
            8'b101_11111: code = 6'h00;
            8'b101_01111: code = 6'h01;
            8'b101_00111: code = 6'h02;
            8'b101_00011: code = 6'h03;
            8'b101_00001: code = 6'h04;
            8'b101_00000: code = 6'h05;
            8'b101_10000: code = 6'h06;
            8'b101_11000: code = 6'h07;
            8'b101_11100: code = 6'h08;
            8'b101_11110: code = 6'h09;
            default: begin
                code  = code_invalid;
                found = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/morse_pkg.sv */
`default_nettype none

package morse_pkg;

    // symbol pattern and count
    localparam int sym_w    = 5;
    localparam int cnt_w    = 3;
    localparam int max_syms = 5;

    // decoded character code, 0x0..0x9 digits then a..z
    localparam int code_w = 6;
    localparam logic [code_w-1:0] code_invalid = 6'h3f;

    // keypad codes
    localparam logic [3:0] key_dash  = 4'he;
    localparam logic [3:0] key_dot   = 4'hf;
    localparam logic [3:0] key_enter = 4'hd;

    // character fifo
    localparam int fifo_depth = 8;
    localparam int lvl_w      = 4;

    // wishbone bus
    localparam int wb_aw = 2;
    localparam int wb_dw = 32;
    localparam logic [wb_aw-1:0] reg_data   = 2'd0;
    localparam logic [wb_aw-1:0] reg_status = 2'd1;
    localparam logic [wb_aw-1:0] reg_ctrl   = 2'd2;

    // status word layout
    localparam int st_level_lsb = 0;
    localparam int st_empty_bit = 4;
    localparam int st_full_bit  = 5;
    localparam int st_ovf_bit   = 6;
    localparam int st_rej_bit   = 7;
    localparam int st_cnt_lsb   = 8;
    localparam int st_pat_lsb   = 11;

    // control word layout
    localparam int ctrl_en_bit  = 0;
    localparam int ctrl_clr_bit = 1;

    // data word layout
    localparam int dat_code_lsb  = 0;
    localparam int dat_valid_bit = 8;

endpackage

`default_nettype wire
